//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam logic [1:0] CLASS_ALU    = 2'b00;
	localparam logic [1:0] CLASS_BRANCH = 2'b01;
	localparam logic [1:0] CLASS_LOAD   = 2'b10;
	localparam logic [1:0] CLASS_STORE  = 2'b11;

	localparam logic [3:0] ALU_ADD  = 4'b0000;
	localparam logic [3:0] ALU_ADDC = 4'b0001;
	localparam logic [3:0] ALU_SUB  = 4'b0010;
	localparam logic [3:0] ALU_SUBC = 4'b0011;
	localparam logic [3:0] ALU_LSL  = 4'b0100;
	localparam logic [3:0] ALU_LSR  = 4'b0101;
	localparam logic [3:0] ALU_AND  = 4'b0110;
	localparam logic [3:0] ALU_XOR  = 4'b0111;
	localparam logic [3:0] ALU_BIC  = 4'b1000;
	localparam logic [3:0] ALU_BST  = 4'b1001;
	localparam logic [3:0] ALU_OR   = 4'b1010;
	localparam logic [3:0] ALU_MOV  = 4'b1011;
	localparam logic [3:0] ALU_CMP  = 4'b1100;
	localparam logic [3:0] ALU_ASR  = 4'b1110;
	localparam logic [3:0] ALU_PASS = 4'b1111;

	localparam logic [2:0] COND_ALWAYS = 3'b111;
	localparam logic [2:0] COND_NZ     = 3'b001;
	localparam logic [2:0] COND_Z      = 3'b010;
	localparam logic [2:0] COND_NC     = 3'b011;
	localparam logic [2:0] COND_C      = 3'b100;

	localparam logic [1:0] WIDTH_WORD = 2'b00;
	localparam logic [1:0] WIDTH_HALF = 2'b01;
	localparam logic [1:0] WIDTH_BYTE = 2'b10;

	// Both views share the top 14 bits, only the low part differs.
	typedef union packed {
		struct packed {
			logic [1:0]  cls;
			logic [3:0]  func;
			logic        imm_sel;
			logic        update_flags;
			logic [2:0]  rd;
			logic [2:0]  ra;
			logic [2:0]  rb;
			logic [14:0] rsvd;
		} r;
		struct packed {
			logic [1:0]  cls;
			logic [3:0]  func;
			logic        imm_sel;
			logic        update_flags;
			logic [2:0]  rd;
			logic [2:0]  ra;
			logic [1:0]  rsvd;
			logic [15:0] imm;
		} i;
	} instr_word_u;

	function automatic logic [31:0] sext_imm(input instr_word_u w);
		return {{16{w.i.imm[15]}}, w.i.imm};
	endfunction

	// Compare and loads write nothing, a call writes its return address.
	function automatic logic writes_reg(input instr_word_u w);
		return (w.r.cls == CLASS_ALU && w.r.func != ALU_CMP) ||
		       (w.r.cls == CLASS_BRANCH && w.r.func[3]);
	endfunction

endpackage

`default_nettype wire

//--- hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	localparam int DATA_W    = 32;
	localparam int REG_COUNT = 8;
	localparam int REG_IDX_W = 3;

	localparam int BUF_DEPTH = 2;
	localparam int BUF_PTR_W = 1; // Index into the issue buffer.
	localparam int BUF_CNT_W = 2; // Holds 0 up to BUF_DEPTH.

endpackage

`default_nettype wire

//--- hdl/register_file.sv
`default_nettype none

module register_file
	import pipe_pkg::*;
(
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire [REG_IDX_W-1:0] rd_addr_a,
	input  wire [REG_IDX_W-1:0] rd_addr_b,
	output logic [DATA_W-1:0]   rd_data_a,
	output logic [DATA_W-1:0]   rd_data_b,
	input  wire                 wr_en,
	input  wire [REG_IDX_W-1:0] wr_addr,
	input  wire [DATA_W-1:0]    wr_data
);

	logic [DATA_W-1:0] regs [REG_COUNT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// A register with a write in flight is never read, so no bypass is needed.
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

//--- hdl/operand_stage.sv
`default_nettype none

module operand_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  wire                  clk,
	input  wire                  rst_n,

	input  wire                  in_valid,
	output logic                 in_ready,
	input  wire [DATA_W-1:0]     in_instr,
	input  wire [DATA_W-1:0]     in_pc,

	output logic [REG_IDX_W-1:0] rd_addr_a,
	output logic [REG_IDX_W-1:0] rd_addr_b,
	input  wire [DATA_W-1:0]     rd_data_a,
	input  wire [DATA_W-1:0]     rd_data_b,

	output logic                 push_valid,
	input  wire                  push_ready,
	output logic [DATA_W-1:0]    push_instr,
	output logic [DATA_W-1:0]    push_pc,
	output logic [DATA_W-1:0]    push_ra_val,
	output logic [DATA_W-1:0]    push_rb_val,

	input  wire                  retire_en,
	input  wire [REG_IDX_W-1:0]  retire_rd
);

	instr_word_u          iw;
	logic [REG_COUNT-1:0] pending;
	logic                 uses_ra;
	logic                 uses_rb;
	logic                 writes_rd;
	logic                 hazard;

	assign iw = in_instr;

	// Branch targets come from the pc alone.
	assign uses_ra = iw.r.cls != CLASS_BRANCH;
	assign uses_rb = (iw.r.cls == CLASS_STORE) ||
	                 (iw.r.cls == CLASS_ALU && !iw.r.imm_sel);
	assign writes_rd = writes_reg(iw);

	// The rd check keeps two writes to one register from being in flight together.
	assign hazard = (uses_ra && pending[iw.r.ra]) ||
	                (uses_rb && pending[iw.r.rb]) ||
	                (writes_rd && pending[iw.r.rd]);

	assign rd_addr_a = iw.r.ra;
	assign rd_addr_b = iw.r.rb;

	assign push_valid  = in_valid && !hazard;
	assign in_ready    = push_ready && !hazard;
	assign push_instr  = in_instr;
	assign push_pc     = in_pc;
	assign push_ra_val = rd_data_a;
	assign push_rb_val = rd_data_b;

	// A set and a clear never hit the same bit in one cycle.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending <= '0;
		end else begin
			if (retire_en)
				pending[retire_rd] <= 1'b0;
			if (push_valid && push_ready && writes_rd)
				pending[iw.r.rd] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/issue_buffer.sv
`default_nettype none

module issue_buffer
	import pipe_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n,

	input  wire               push_valid,
	output logic              push_ready,
	input  wire [DATA_W-1:0]  push_instr,
	input  wire [DATA_W-1:0]  push_pc,
	input  wire [DATA_W-1:0]  push_ra_val,
	input  wire [DATA_W-1:0]  push_rb_val,

	output logic              op_valid,
	input  wire               op_ready,
	output logic [DATA_W-1:0] op_instr,
	output logic [DATA_W-1:0] op_pc,
	output logic [DATA_W-1:0] op_ra_val,
	output logic [DATA_W-1:0] op_rb_val
);

	logic [DATA_W-1:0]    instr_q [BUF_DEPTH];
	logic [DATA_W-1:0]    pc_q    [BUF_DEPTH];
	logic [DATA_W-1:0]    ra_q    [BUF_DEPTH];
	logic [DATA_W-1:0]    rb_q    [BUF_DEPTH];
	logic [BUF_PTR_W-1:0] wr_ptr;
	logic [BUF_PTR_W-1:0] rd_ptr;
	logic [BUF_CNT_W-1:0] count;
	logic                 push_fire;
	logic                 pop_fire;

	assign op_valid   = count != '0;
	assign push_ready = (count != BUF_CNT_W'(BUF_DEPTH)) || op_ready; // Full but draining.
	assign push_fire  = push_valid && push_ready;
	assign pop_fire   = op_valid && op_ready;

	assign op_instr  = instr_q[rd_ptr];
	assign op_pc     = pc_q[rd_ptr];
	assign op_ra_val = ra_q[rd_ptr];
	assign op_rb_val = rb_q[rd_ptr];

	always_ff @(posedge clk) begin
		if (push_fire) begin
			instr_q[wr_ptr] <= push_instr;
			pc_q[wr_ptr]    <= push_pc;
			ra_q[wr_ptr]    <= push_ra_val;
			rb_q[wr_ptr]    <= push_rb_val;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_fire)
				wr_ptr <= (wr_ptr == BUF_PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_fire)
				rd_ptr <= (rd_ptr == BUF_PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push_fire && !pop_fire)
				count <= count + 1'b1;
			else if (pop_fire && !push_fire)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/exec_stage.sv
`default_nettype none

module exec_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  wire                  clk,
	input  wire                  rst_n,

	input  wire                  op_valid,
	output logic                 op_ready,
	input  wire [DATA_W-1:0]     op_instr,
	input  wire [DATA_W-1:0]     op_pc,
	input  wire [DATA_W-1:0]     op_ra_val,
	input  wire [DATA_W-1:0]     op_rb_val,

	output logic                 res_valid,
	input  wire                  res_ready,
	output logic [DATA_W-1:0]    res_pc,
	output logic                 res_wr,
	output logic [REG_IDX_W-1:0] res_rd,
	output logic [DATA_W-1:0]    res_val,
	output logic                 res_mem_load,
	output logic                 res_mem_store,
	output logic [1:0]           res_mem_width,
	output logic [DATA_W-1:0]    res_mar,
	output logic [DATA_W-1:0]    res_mdr,
	output logic                 res_branch_taken,
	output logic [DATA_W-1:0]    res_target
);

	instr_word_u       iw;
	logic [DATA_W-1:0] imm32;
	logic [DATA_W-1:0] pc_plus_4;
	logic [DATA_W-1:0] op1;
	logic [DATA_W-1:0] op2;
	logic [DATA_W-1:0] alu_q;
	logic              alu_c;
	logic [3:0]        alu_opc;
	logic              is_alu;
	logic              is_branch;
	logic              is_call;
	logic              cond_met;
	logic              fire;
	logic              z_flag;
	logic              c_flag;

	assign iw        = op_instr;
	assign imm32     = sext_imm(iw);
	assign pc_plus_4 = op_pc + 32'd4;
	assign is_alu    = iw.r.cls == CLASS_ALU;
	assign is_branch = iw.r.cls == CLASS_BRANCH;
	assign is_call   = is_branch && iw.r.func[3];

	// Memory addresses and branch targets reuse the adder.
	assign alu_opc = is_alu ? iw.r.func : ALU_ADD;
	assign op1     = is_branch ? pc_plus_4 : op_ra_val;
	assign op2     = (is_alu && !iw.r.imm_sel) ? op_rb_val : imm32;

	always_comb begin
		alu_c = 1'b0;
		case (alu_opc)
		ALU_ADD:  {alu_c, alu_q} = op1 + op2;
		ALU_ADDC: {alu_c, alu_q} = op1 + op2 + c_flag;
		ALU_SUB:  {alu_c, alu_q} = op1 - op2;
		ALU_SUBC: {alu_c, alu_q} = op1 - op2 + c_flag;
		ALU_LSL:  {alu_c, alu_q} = {1'b0, op1} << op2[4:0];
		ALU_LSR:  alu_q = op1 >> op2[4:0];
		ALU_AND:  alu_q = op1 & op2;
		ALU_XOR:  alu_q = op1 ^ op2;
		ALU_BIC:  alu_q = op1 & ~(32'd1 << op2[4:0]);
		ALU_BST:  alu_q = op1 | (32'd1 << op2[4:0]);
		ALU_OR:   alu_q = op1 | op2;
		ALU_MOV:  alu_q = op2;
		ALU_CMP:  {alu_c, alu_q} = op1 - op2; // Only the flags are kept.
		ALU_ASR:  alu_q = $signed(op1) >>> op2[4:0];
		ALU_PASS: alu_q = op1;
		default:  alu_q = '0;
		endcase
	end

	always_comb begin
		case (iw.r.func[2:0])
		COND_ALWAYS: cond_met = 1'b1;
		COND_NZ:     cond_met = !z_flag;
		COND_Z:      cond_met = z_flag;
		COND_NC:     cond_met = !c_flag;
		COND_C:      cond_met = c_flag;
		default:     cond_met = 1'b0;
		endcase
	end

	assign op_ready = !res_valid || res_ready;
	assign fire     = op_valid && op_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_valid        <= 1'b0;
			res_wr           <= 1'b0;
			res_mem_load     <= 1'b0;
			res_mem_store    <= 1'b0;
			res_branch_taken <= 1'b0;
			z_flag           <= 1'b0;
			c_flag           <= 1'b0;
		end else if (fire) begin
			res_valid        <= 1'b1;
			res_wr           <= writes_reg(iw);
			res_mem_load     <= iw.r.cls == CLASS_LOAD;
			res_mem_store    <= iw.r.cls == CLASS_STORE;
			res_branch_taken <= is_branch && cond_met;
			if (is_alu && iw.r.update_flags) begin
				z_flag <= op1 == op2;
				c_flag <= alu_c;
			end
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			res_pc        <= op_pc;
			res_rd        <= iw.r.rd;
			res_val       <= is_call ? pc_plus_4 : alu_q;
			res_mem_width <= iw.r.func[1:0];
			res_mar       <= alu_q;
			res_mdr       <= op_rb_val;
			res_target    <= alu_q;
		end
	end

endmodule

`default_nettype wire

//--- hdl/exec_core.sv
`default_nettype none

module exec_core
	import pipe_pkg::*;
(
	input  wire                  clk,
	input  wire                  rst_n,

	input  wire                  in_valid,
	output logic                 in_ready,
	input  wire [DATA_W-1:0]     in_instr,
	input  wire [DATA_W-1:0]     in_pc,

	output logic                 res_valid,
	input  wire                  res_ready,
	output logic [DATA_W-1:0]    res_pc,
	output logic                 res_wr,
	output logic [REG_IDX_W-1:0] res_rd,
	output logic [DATA_W-1:0]    res_val,
	output logic                 res_mem_load,
	output logic                 res_mem_store,
	output logic [1:0]           res_mem_width,
	output logic [DATA_W-1:0]    res_mar,
	output logic [DATA_W-1:0]    res_mdr,
	output logic                 res_branch_taken,
	output logic [DATA_W-1:0]    res_target
);

	logic [REG_IDX_W-1:0] rd_addr_a;
	logic [REG_IDX_W-1:0] rd_addr_b;
	logic [DATA_W-1:0]    rd_data_a;
	logic [DATA_W-1:0]    rd_data_b;
	logic                 push_valid;
	logic                 push_ready;
	logic [DATA_W-1:0]    push_instr;
	logic [DATA_W-1:0]    push_pc;
	logic [DATA_W-1:0]    push_ra_val;
	logic [DATA_W-1:0]    push_rb_val;
	logic                 op_valid;
	logic                 op_ready;
	logic [DATA_W-1:0]    op_instr;
	logic [DATA_W-1:0]    op_pc;
	logic [DATA_W-1:0]    op_ra_val;
	logic [DATA_W-1:0]    op_rb_val;
	logic                 wr_en;

	// Writeback and the scoreboard clear both happen when a result is taken.
	assign wr_en = res_valid && res_ready && res_wr;

	register_file u_regs (
		.clk, .rst_n,
		.rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
		.wr_en, .wr_addr(res_rd), .wr_data(res_val)
	);

	operand_stage u_operand (
		.clk, .rst_n,
		.in_valid, .in_ready, .in_instr, .in_pc,
		.rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
		.push_valid, .push_ready, .push_instr, .push_pc, .push_ra_val, .push_rb_val,
		.retire_en(wr_en), .retire_rd(res_rd)
	);

	issue_buffer u_buffer (
		.clk, .rst_n,
		.push_valid, .push_ready, .push_instr, .push_pc, .push_ra_val, .push_rb_val,
		.op_valid, .op_ready, .op_instr, .op_pc, .op_ra_val, .op_rb_val
	);

	exec_stage u_exec (
		.clk, .rst_n,
		.op_valid, .op_ready, .op_instr, .op_pc, .op_ra_val, .op_rb_val,
		.res_valid, .res_ready, .res_pc, .res_wr, .res_rd, .res_val,
		.res_mem_load, .res_mem_store, .res_mem_width, .res_mar, .res_mdr,
		.res_branch_taken, .res_target
	);

endmodule

`default_nettype wire

//--- test/exec_core_assert.sv
`default_nettype none

module exec_core_assert
	import pipe_pkg::*;
(
	input wire                 clk,
	input wire                 rst_n,
	input wire                 in_valid,
	input wire                 in_ready,
	input wire [DATA_W-1:0]    in_instr,
	input wire [DATA_W-1:0]    in_pc,
	input wire                 res_valid,
	input wire                 res_ready,
	input wire [DATA_W-1:0]    res_pc,
	input wire                 res_wr,
	input wire [REG_IDX_W-1:0] res_rd,
	input wire [DATA_W-1:0]    res_val,
	input wire                 res_mem_load,
	input wire                 res_mem_store,
	input wire [1:0]           res_mem_width,
	input wire [DATA_W-1:0]    res_mar,
	input wire [DATA_W-1:0]    res_mdr,
	input wire                 res_branch_taken,
	input wire [DATA_W-1:0]    res_target
);

	int fail_count = 0;

	a_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !res_valid)
		else begin
			fail_count++;
			$error("res_valid is high right after reset");
		end

	// The whole result word must hold while the consumer stalls.
	a_result_held: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid && !res_ready |=> res_valid && $stable({res_pc, res_wr, res_rd, res_val,
			res_mem_load, res_mem_store, res_mem_width, res_mar, res_mdr,
			res_branch_taken, res_target}))
		else begin
			fail_count++;
			$error("result changed or dropped while res_ready was low");
		end

	a_input_held: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && !in_ready |=> in_valid && $stable(in_instr) && $stable(in_pc))
		else begin
			fail_count++;
			$error("input instruction changed or dropped while in_ready was low");
		end

endmodule

`default_nettype wire

//--- test/exec_core_tb.sv
`default_nettype none

module exec_core_tb
	import isa_pkg::*;
	import pipe_pkg::*;
();

	localparam int          CLK_PERIOD       = 100;
	localparam int          RESET_CYCLES     = 16;
	localparam int          N_INSTR          = 400;
	localparam int          CYCLES_PER_INSTR = 20;
	localparam int          DRAIN_CYCLES     = 20;
	localparam int          WATCHDOG_CYCLES  =
		RESET_CYCLES + N_INSTR * CYCLES_PER_INSTR + DRAIN_CYCLES;
	localparam logic [31:0] SEED             = 32'h401e9fe8;
	localparam logic [31:0] PC_BASE          = 32'h0000_1000;

	typedef struct packed {
		logic [31:0] pc;
		logic        wr;
		logic [2:0]  rd;
		logic [31:0] val;
		logic        load;
		logic        store;
		logic        branch;
		logic [1:0]  width;
		logic [31:0] mar;
		logic [31:0] mdr;
		logic        taken;
		logic [31:0] target;
	} expect_t;

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	logic                 in_ready;
	logic [DATA_W-1:0]    in_instr;
	logic [DATA_W-1:0]    in_pc;
	logic                 res_valid;
	logic                 res_ready;
	logic [DATA_W-1:0]    res_pc;
	logic                 res_wr;
	logic [REG_IDX_W-1:0] res_rd;
	logic [DATA_W-1:0]    res_val;
	logic                 res_mem_load;
	logic                 res_mem_store;
	logic [1:0]           res_mem_width;
	logic [DATA_W-1:0]    res_mar;
	logic [DATA_W-1:0]    res_mdr;
	logic                 res_branch_taken;
	logic [DATA_W-1:0]    res_target;

	integer      seed;
	int          n_in;
	int          n_out;
	int          err_val;
	int          err_other;
	logic        in_fire;
	logic        res_fire;
	logic [31:0] model_regs [REG_COUNT];
	logic        model_z;
	logic        model_c;
	expect_t     expect_q [$];

	exec_core dut (
		.clk, .rst_n,
		.in_valid, .in_ready, .in_instr, .in_pc,
		.res_valid, .res_ready, .res_pc, .res_wr, .res_rd, .res_val,
		.res_mem_load, .res_mem_store, .res_mem_width, .res_mar, .res_mdr,
		.res_branch_taken, .res_target
	);

	bind exec_core exec_core_assert u_assert (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Returns the carry in bit 32 above the 32-bit result.
	function automatic logic [32:0] alu_model(input logic [3:0] f, input logic [31:0] a,
			input logic [31:0] b, input logic cin);
		logic [4:0]         sh;
		logic signed [31:0] sa;
		sh = b[4:0];
		sa = a;
		case (f)
		ALU_ADD:          return {1'b0, a} + {1'b0, b};
		ALU_ADDC:         return {1'b0, a} + {1'b0, b} + {32'd0, cin};
		ALU_SUB, ALU_CMP: return {1'b0, a} - {1'b0, b};
		ALU_SUBC:         return {1'b0, a} - {1'b0, b} + {32'd0, cin};
		ALU_LSL:          return {1'b0, a} << sh;
		ALU_LSR:          return {1'b0, a >> sh};
		ALU_AND:          return {1'b0, a & b};
		ALU_XOR:          return {1'b0, a ^ b};
		ALU_BIC:          return {1'b0, a & ~(32'd1 << sh)};
		ALU_BST:          return {1'b0, a | (32'd1 << sh)};
		ALU_OR:           return {1'b0, a | b};
		ALU_MOV:          return {1'b0, b};
		ALU_ASR:          return {1'b0, sa >>> sh};
		ALU_PASS:         return {1'b0, a};
		default:          return 33'd0;
		endcase
	endfunction

	function automatic logic cond_true(input logic [2:0] cond);
		case (cond)
		COND_ALWAYS: return 1'b1;
		COND_NZ:     return !model_z;
		COND_Z:      return model_z;
		COND_NC:     return !model_c;
		COND_C:      return model_c;
		default:     return 1'b0;
		endcase
	endfunction

	// Runs one instruction on the architectural model and queues what the DUT must report.
	task automatic predict(input logic [31:0] word, input logic [31:0] pc);
		expect_t     e;
		logic [3:0]  f;
		logic [31:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		logic [32:0] wide;
		f = word[29:26];
		imm = {{16{word[15]}}, word[15:0]};
		a = model_regs[word[20:18]];
		b = word[25] ? imm : model_regs[word[17:15]];
		e = '0;
		e.pc = pc;
		e.rd = word[23:21];
		e.width = f[1:0];
		case (word[31:30])
		CLASS_ALU: begin
			wide = alu_model(f, a, b, model_c);
			e.val = wide[31:0];
			e.wr = f != ALU_CMP;
			if (word[24]) begin
				model_z = a == b;
				model_c = wide[32];
			end
		end
		CLASS_BRANCH: begin
			e.branch = 1'b1;
			e.target = pc + 32'd4 + imm;
			e.taken = cond_true(f[2:0]);
			if (f[3]) begin // Call.
				e.wr = 1'b1;
				e.val = pc + 32'd4;
			end
		end
		CLASS_LOAD: begin
			e.load = 1'b1;
			e.mar = a + imm;
		end
		default: begin
			e.store = 1'b1;
			e.mar = a + imm;
			e.mdr = model_regs[word[17:15]];
		end
		endcase
		if (e.wr)
			model_regs[e.rd] = e.val;
		expect_q.push_back(e);
	endtask

	task automatic compare_field(input string name, input logic [31:0] got,
			input logic [31:0] want, input logic [31:0] pc);
		if (got !== want) begin
			err_val++;
			$display("ERR %s: got %h expected %h (pc %h)", name, got, want, pc);
		end
	endtask

	task automatic check_result();
		expect_t e;
		n_out++;
		if (expect_q.size() == 0) begin
			err_other++;
			$display("a result for pc %h arrived with no instruction outstanding", res_pc);
		end else begin
			e = expect_q.pop_front();
			compare_field("res_pc", res_pc, e.pc, e.pc);
			compare_field("res_wr", res_wr, e.wr, e.pc);
			compare_field("res_mem_load", res_mem_load, e.load, e.pc);
			compare_field("res_mem_store", res_mem_store, e.store, e.pc);
			compare_field("res_branch_taken", res_branch_taken, e.taken, e.pc);
			if (e.wr) begin
				compare_field("res_rd", res_rd, e.rd, e.pc);
				compare_field("res_val", res_val, e.val, e.pc);
			end
			if (e.load || e.store) begin
				compare_field("res_mar", res_mar, e.mar, e.pc);
				compare_field("res_mem_width", res_mem_width, e.width, e.pc);
			end
			if (e.store)
				compare_field("res_mdr", res_mdr, e.mdr, e.pc);
			if (e.branch)
				compare_field("res_target", res_target, e.target, e.pc);
		end
	endtask

	// A held instruction stays on the port until the DUT takes it.
	task automatic drive_inputs(input logic accepted);
		if (accepted || !in_valid) begin
			if (n_in < N_INSTR && ($random(seed) & 3) != 0) begin
				in_valid = 1'b1;
				in_instr = $random(seed);
				in_pc = PC_BASE + 32'(4 * n_in);
			end else begin
				in_valid = 1'b0;
			end
		end
		res_ready = ($random(seed) & 3) != 0;
	endtask

	initial begin
		seed = SEED;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		in_pc = '0;
		res_ready = 1'b0;
		n_in = 0;
		n_out = 0;
		err_val = 0;
		err_other = 0;
		model_z = 1'b0;
		model_c = 1'b0;
		for (int i = 0; i < REG_COUNT; i++)
			model_regs[i] = '0;

		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		// Handshakes are read at the rising edge, before the DUT's flops update.
		while (n_out < N_INSTR) begin
			@(posedge clk);
			in_fire = in_valid && in_ready;
			res_fire = res_valid && res_ready;
			if (res_fire)
				check_result();
			if (in_fire) begin
				predict(in_instr, in_pc);
				n_in++;
			end
			@(negedge clk);
			drive_inputs(in_fire);
		end

		repeat (DRAIN_CYCLES) begin
			@(posedge clk);
			if (res_valid) begin
				err_other++;
				$display("res_valid rose again after the last result, pc %h", res_pc);
			end
			@(negedge clk);
			res_ready = ($random(seed) & 3) != 0;
		end

		$display("results %0d of %0d, value errors %0d, other errors %0d, assertion errors %0d",
			n_out, N_INSTR, err_val, err_other, dut.u_assert.fail_count);
		if (err_val == 0 && err_other == 0 && dut.u_assert.fail_count == 0 &&
				expect_q.size() == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout with %0d of %0d results seen", n_out, N_INSTR);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/register_file.sv
hdl/operand_stage.sv
hdl/issue_buffer.sv
hdl/exec_stage.sv
hdl/exec_core.sv
test/exec_core_assert.sv
test/exec_core_tb.sv

//--- Bender.yml
package:
  name: exec_core

sources:
  - files:
      - hdl/isa_pkg.sv
      - hdl/pipe_pkg.sv
      - hdl/register_file.sv
      - hdl/operand_stage.sv
      - hdl/issue_buffer.sv
      - hdl/exec_stage.sv
      - hdl/exec_core.sv
  - target: test
    files:
      - test/exec_core_assert.sv
      - test/exec_core_tb.sv
